// File: sources.f
+incdir+include
verilog/lb_slave_pkg.sv
verilog/event_sync.sv
verilog/event_counter.sv
verilog/lb_write_decode.sv
verilog/led_pwm.sv
verilog/lb_readback.sv
verilog/lb_slave_top.sv
verification/lb_tb_clock.sv
verification/lb_slave_tb.sv

// File: Bender.yml
package:
  name: lb_slave

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/lb_slave_pkg.sv
      - verilog/event_sync.sv
      - verilog/event_counter.sv
      - verilog/lb_write_decode.sv
      - verilog/led_pwm.sv
      - verilog/lb_readback.sv
      - verilog/lb_slave_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/lb_tb_clock.sv
      - verification/lb_slave_tb.sv

// File: verification/lb_slave_tb.sv
// Directed testbench for the local-bus slave, run as the simulation top with sources.f
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module lb_slave_tb;

	logic                    clk;
	logic                    arst_n;
	logic [`LB_ADDR_W-1:0]   addr;
	logic                    strobe;
	logic                    rd;
	logic [`LB_DATA_W-1:0]   wdata;
	logic [`LB_N_EVENTS-1:0] events;
	logic [`LB_DATA_W-1:0]   data_in;
	logic                    led_user;
	logic                    led1;
	logic                    led2;

	int seed = 67;

	lb_tb_clock u_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	lb_slave_top UUT (
		.clk      (clk),
		.arst_n   (arst_n),
		.addr     (addr),
		.strobe   (strobe),
		.rd       (rd),
		.wdata    (wdata),
		.events   (events),
		.data_in  (data_in),
		.led_user (led_user),
		.led1     (led1),
		.led2     (led2)
	);

	// Compare and stop at the first mismatch
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// Non-value failures such as timeouts
	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// Write with the strobe sampled on one edge and no wait states
	task automatic bus_write(input logic [23:0] a, input logic [31:0] d);
		@(posedge clk);
		#1;
		addr   = a;
		wdata  = d;
		rd     = 1'b0;
		strobe = 1'b1;
		@(posedge clk);
		#1;
		strobe = 1'b0;
	endtask

	// Read with data_in valid after the second edge past the strobe
	task automatic bus_read(input logic [23:0] a, output logic [31:0] d);
		@(posedge clk);
		#1;
		addr   = a;
		rd     = 1'b1;
		strobe = 1'b1;
		@(posedge clk);
		#1;
		strobe = 1'b0;
		rd     = 1'b0;
		@(posedge clk);
		#1;
		d = data_in;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (!arst_n && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!arst_n) fail_now("reset never released");
	endtask

	// Sel 1 watches led1 and anything else led2
	// Returns on the cycle the LED is first seen high
	task automatic wait_led_rise(input int sel);
		int   n;
		logic prev;
		logic cur;
		logic done;
		n    = 0;
		done = 1'b0;
		prev = (sel == 1) ? led1 : led2;
		while (!done && n < 2048) begin
			@(posedge clk);
			#1;
			cur = (sel == 1) ? led1 : led2;
			if (!prev && cur) done = 1'b1;
			prev = cur;
			n++;
		end
		if (!done) fail_now($sformatf("led%0d did not rise within 2048 cycles", sel));
	endtask

	// ID words, zero state and an unmapped page
	task automatic reset_defaults();
		logic [31:0] d;
		logic [31:0] id0;
		logic [31:0] id1;
		id0 = "LBSL";
		id1 = "v1.0";
		check_value("reset led_user", 32'd0, {31'd0, led_user});
		check_value("reset led1", 32'd0, {31'd0, led1});
		check_value("reset led2", 32'd0, {31'd0, led2});
		bus_read(24'h00_0000, d);
		check_value("id0", id0, d);
		bus_read(24'h00_0001, d);
		check_value("id1", id1, d);
		bus_read(24'h00_0003, d);
		check_value("reset ctrl", 32'd0, d);
		for (int i = 0; i < `LB_N_EVENTS; i++) begin
			bus_read(24'h01_0000 | i, d);
			check_value($sformatf("reset count %0d", i), 32'd0, d);
		end
		bus_read(24'h02_0000, d);
		check_value("unmapped page", 32'hdeadbeef, d);
	endtask

	// REG_CTRL is {led_user, duty_1, duty_2} zero-extended
	task automatic ctrl_write_readback();
		logic [31:0] d;
		logic [7:0]  d1;
		logic [7:0]  d2;
		d1 = $random(seed);
		d2 = $random(seed);
		bus_write(24'h05_0001, 32'h0000_0001);
		check_value("led_user set", 32'd1, {31'd0, led_user});
		bus_write(24'h05_0002, {24'hffffff, d1});
		bus_write(24'h05_0003, {24'h0, d2});
		bus_read(24'h00_0003, d);
		check_value("ctrl with led on", {15'd0, 1'b1, d1, d2}, d);
		bus_write(24'h05_0001, 32'hffff_fffe);
		check_value("led_user clear", 32'd0, {31'd0, led_user});
		bus_read(24'h00_0003, d);
		check_value("ctrl with led off", {15'd0, 1'b0, d1, d2}, d);
	endtask

	// Every page 5 write lands in the mirror
	task automatic mirror_readback();
		logic [31:0] exp_mem [32];
		logic [31:0] d;
		for (int ofs = 5; ofs < 32; ofs++) begin
			exp_mem[ofs] = $random(seed);
			bus_write(24'h05_0000 | ofs, exp_mem[ofs]);
		end
		// Offsets with side effects are stored too
		for (int ofs = 1; ofs < 5; ofs++) begin
			exp_mem[ofs] = $random(seed);
			bus_write(24'h05_0000 | ofs, exp_mem[ofs]);
		end
		for (int ofs = 1; ofs < 32; ofs++) begin
			bus_read(24'h05_0000 | ofs, d);
			check_value($sformatf("mirror word %0d", ofs), exp_mem[ofs], d);
		end
	endtask

	// Channel i gets i+2 pulses with rising edges 6 cycles apart
	task automatic event_counting();
		logic [31:0] d;
		int          max_p;
		bus_write(24'h05_0004, 32'h0);
		max_p = `LB_N_EVENTS + 1;
		for (int p = 0; p < max_p; p++) begin
			@(posedge clk);
			#1;
			for (int i = 0; i < `LB_N_EVENTS; i++) begin
				events[i] = (p < i + 2);
			end
			repeat (2) @(posedge clk);
			#1;
			events = '0;
			repeat (3) @(posedge clk);
		end
		// Sync plus edge register takes 3 cycles
		repeat (5) @(posedge clk);
		for (int i = 0; i < `LB_N_EVENTS; i++) begin
			bus_read(24'h01_0000 | i, d);
			check_value($sformatf("event count %0d", i), i + 2, d);
		end
		bus_write(24'h05_0004, 32'h0);
		for (int i = 0; i < `LB_N_EVENTS; i++) begin
			bus_read(24'h01_0000 | i, d);
			check_value($sformatf("cleared count %0d", i), 32'd0, d);
		end
	endtask

	// Duty d gives 4d high cycles per 1024
	// Uptime grows by one per window
	task automatic pwm_duty_and_uptime();
		logic [7:0]  d1;
		logic [7:0]  d2;
		logic [31:0] u0;
		logic [31:0] u1;
		logic [31:0] diff;
		int          h1;
		int          h2;
		int          k;
		d1 = ($unsigned($random(seed)) % 255) + 1;
		d2 = ($unsigned($random(seed)) % 255) + 1;
		bus_write(24'h05_0002, {24'h0, d1});
		bus_write(24'h05_0003, {24'h0, d2});
		wait_led_rise(1);
		h1 = 0;
		h2 = 0;
		for (int n = 0; n < 1024; n++) begin
			if (led1) h1++;
			if (led2) h2++;
			@(posedge clk);
			#1;
		end
		check_value("led1 high cycles", 4 * d1, h1);
		check_value("led2 high cycles", 4 * d2, h2);
		k = 3;
		wait_led_rise(1);
		bus_read(24'h00_0002, u0);
		for (int w = 0; w < k; w++) begin
			wait_led_rise(1);
		end
		bus_read(24'h00_0002, u1);
		diff = u1 - u0;
		$display("uptime grew by %0d over %0d windows", diff, k);
		// Off by more than one count
		if ((diff + 1 < k) || (diff > k + 1)) begin
			check_value("uptime growth", k, diff);
		end
	endtask

	initial begin
		addr   = '0;
		strobe = 1'b0;
		rd     = 1'b0;
		wdata  = '0;
		events = '0;
		wait_reset_release();
		reset_defaults();
		ctrl_write_readback();
		mirror_readback();
		event_counting();
		pwm_duty_and_uptime();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: verification/lb_tb_clock.sv
// Testbench clock and reset source for the local-bus slave, instantiated by the top testbench
`timescale 1ns/1ps

module lb_tb_clock (
	output logic clk,
	output logic arst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
	end

	always #5 clk = ~clk;

	// Reset held low for 4 rising edges, released just after the edge
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
	end

endmodule

// File: verilog/lb_slave_top.sv
// Local-bus slave top level: write decode, event counters, LED PWM and read pipeline
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module lb_slave_top (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic [`LB_ADDR_W-1:0]   addr,
	input  logic                    strobe,
	input  logic                    rd,
	input  logic [`LB_DATA_W-1:0]   wdata,
	input  logic [`LB_N_EVENTS-1:0] events,
	output logic [`LB_DATA_W-1:0]   data_in,
	output logic                    led_user,
	output logic                    led1,
	output logic                    led2
);

	import lb_slave_pkg::*;

	lb_req_t    req;
	ctrl_regs_t ctrl;
	mirror_wr_t mirror_wr;
	logic       cnt_clear;
	logic [31:0] uptime;
	logic [`LB_N_EVENTS-1:0] evt_strb;
	logic [`LB_N_EVENTS-1:0][`LB_EVT_CNT_W-1:0] counts;

	// Bundle the bus pins
	assign req = '{addr: addr, strobe: strobe, rd: rd, wdata: wdata};

	assign led_user = ctrl.led_user;

	lb_write_decode u_write_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.ctrl      (ctrl),
		.mirror_wr (mirror_wr),
		.cnt_clear (cnt_clear)
	);

	event_sync #(.N(`LB_N_EVENTS)) u_event_sync (
		.clk    (clk),
		.arst_n (arst_n),
		.events (events),
		.strb   (evt_strb)
	);

	// One counter per channel, all share the clear
	for (genvar i = 0; i < `LB_N_EVENTS; i++) begin : g_evt
		event_counter #(.CNT_W(`LB_EVT_CNT_W)) u_counter (
			.clk    (clk),
			.arst_n (arst_n),
			.strb   (evt_strb[i]),
			.clear  (cnt_clear),
			.count  (counts[i])
		);
	end

	led_pwm #(.CW(`LB_PWM_CW)) u_led_pwm (
		.clk    (clk),
		.arst_n (arst_n),
		.ctrl   (ctrl),
		.led1   (led1),
		.led2   (led2),
		.uptime (uptime)
	);

	lb_readback u_readback (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.ctrl      (ctrl),
		.mirror_wr (mirror_wr),
		.uptime    (uptime),
		.counts    (counts),
		.data_in   (data_in)
	);

endmodule

// File: verilog/lb_readback.sv
// Mirror RAM and two-stage read pipeline that drives data_in with fixed 2-cycle latency
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module lb_readback (
	input  logic                                           clk,
	input  logic                                           arst_n,
	input  lb_slave_pkg::lb_req_t                          req,
	input  lb_slave_pkg::ctrl_regs_t                       ctrl,
	input  lb_slave_pkg::mirror_wr_t                       mirror_wr,
	input  logic [31:0]                                    uptime,
	input  logic [`LB_N_EVENTS-1:0][`LB_EVT_CNT_W-1:0]     counts,
	output logic [`LB_DATA_W-1:0]                          data_in
);

	import lb_slave_pkg::*;

	localparam int EVT_SEL_W = $clog2(`LB_N_EVENTS);
	localparam int MIRROR_WORDS = 2 ** `LB_MIRROR_AW;

	// Mirror storage, contents undefined until written
	logic [`LB_DATA_W-1:0] mirror_mem [MIRROR_WORDS];

	logic                  do_rd;
	logic                  do_rd_r;
	logic [`LB_ADDR_W-1:0] addr_r;
	logic [`LB_DATA_W-1:0] reg_word;
	logic [`LB_DATA_W-1:0] mirror_q;
	logic [`LB_DATA_W-1:0] evt_word;
	lb_reg_e               rd_ofs;
	lb_page_e              page_r;

	assign do_rd  = req.strobe & req.rd;
	assign rd_ofs = lb_reg_e'(req.addr[3:0]);
	assign page_r = lb_page_e'(addr_r[`LB_PAGE_HI:`LB_PAGE_LO]);

	// Write port, fed by the decoder
	always_ff @(posedge clk) begin
		if (mirror_wr.en) begin
			mirror_mem[mirror_wr.addr] <= mirror_wr.data;
		end
	end

	// Stage one valid flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	// Stage one: page 0 word, mirror read port, address
	always_ff @(posedge clk) begin
		if (do_rd) begin
			addr_r   <= req.addr;
			mirror_q <= mirror_mem[req.addr[`LB_MIRROR_AW-1:0]];
			case (rd_ofs)
				REG_ID0:    reg_word <= `LB_ID_0;
				REG_ID1:    reg_word <= `LB_ID_1;
				REG_UPTIME: reg_word <= uptime;
				REG_CTRL:   reg_word <= `LB_DATA_W'(ctrl);
				default:    reg_word <= `LB_UNMAPPED;
			endcase
		end
	end

	// Counter pick from the latched address
	// Offsets past the last channel read as unmapped
	always_comb begin
		if (addr_r[3:0] < `LB_N_EVENTS) begin
			evt_word = `LB_DATA_W'(counts[addr_r[EVT_SEL_W-1:0]]);
		end else begin
			evt_word = `LB_UNMAPPED;
		end
	end

	// Stage two: page select, holds until the next read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			case (page_r)
				PAGE_REGS:   data_in <= reg_word;
				PAGE_EVENTS: data_in <= evt_word;
				PAGE_CTRL:   data_in <= mirror_q;
				default:     data_in <= `LB_UNMAPPED;
			endcase
		end
	end

endmodule

// File: verilog/led_pwm.sv
// Free-running PWM for two LEDs with duty from the control registers, plus an uptime count
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module led_pwm #(
	parameter int CW = `LB_PWM_CW
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  lb_slave_pkg::ctrl_regs_t ctrl,
	output logic                     led1,
	output logic                     led2,
	output logic [31:0]              uptime
);

	logic [CW-1:0] pwm_cc;
	logic          pwm_wrap;
	// Duty factors scaled by 4
	logic [CW-1:0] thr_1;
	logic [CW-1:0] thr_2;

	assign thr_1 = CW'({ctrl.duty_1, 2'b00});
	assign thr_2 = CW'({ctrl.duty_2, 2'b00});

	// Counter carry lands in pwm_wrap, one cycle wide per period
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pwm_cc   <= '0;
			pwm_wrap <= 1'b0;
		end else begin
			{pwm_wrap, pwm_cc} <= pwm_cc + 1'b1;
		end
	end

	// Compare registered, LEDs trail the counter by one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= pwm_cc < thr_1;
			led2 <= pwm_cc < thr_2;
		end
	end

	// Uptime in PWM periods
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			uptime <= '0;
		end else if (pwm_wrap) begin
			uptime <= uptime + 1'b1;
		end
	end

endmodule

// File: verilog/lb_write_decode.sv
// Turns page 5 bus writes into control registers, the counter clear pulse and mirror writes
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module lb_write_decode (
	input  logic                     clk,
	input  logic                     arst_n,
	input  lb_slave_pkg::lb_req_t    req,
	output lb_slave_pkg::ctrl_regs_t ctrl,
	output lb_slave_pkg::mirror_wr_t mirror_wr,
	output logic                     cnt_clear
);

	import lb_slave_pkg::*;

	logic   wr_cycle;
	logic   wr_page;
	lb_wr_e wr_ofs;

	// Write is strobe with rd low
	assign wr_cycle = req.strobe & ~req.rd;
	assign wr_page  = wr_cycle & (req.addr[`LB_PAGE_HI:`LB_PAGE_LO] == PAGE_CTRL);

	// Only the low nibble selects a register
	assign wr_ofs = lb_wr_e'(req.addr[3:0]);

	// Control registers update on the edge that sees the strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
		end else if (wr_page) begin
			case (wr_ofs)
				WR_LED_USER: ctrl.led_user <= req.wdata[0];
				WR_DUTY_1:   ctrl.duty_1   <= req.wdata[7:0];
				WR_DUTY_2:   ctrl.duty_2   <= req.wdata[7:0];
				// Clear is handled as a pulse below
				default: ;
			endcase
		end
	end

	// Registered clear, high for the cycle after the write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt_clear <= 1'b0;
		end else begin
			cnt_clear <= wr_page & (wr_ofs == WR_CNT_CLEAR);
		end
	end

	// Every write on the page lands in the mirror
	// including offsets 1 to 4, so software reads back what it wrote
	always_comb begin
		mirror_wr.en   = wr_page;
		mirror_wr.addr = req.addr[`LB_MIRROR_AW-1:0];
		mirror_wr.data = req.wdata;
	end

endmodule

// File: verilog/event_counter.sv
// Wrapping event counter with synchronous clear, one instance per event channel
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module event_counter #(
	parameter int CNT_W = `LB_EVT_CNT_W
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             strb,
	input  logic             clear,
	output logic [CNT_W-1:0] count
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (clear) begin
			// Clear wins over a coincident strobe
			count <= '0;
		end else if (strb) begin
			// Wraps to zero past full scale
			count <= count + 1'b1;
		end
	end

endmodule

// File: verilog/event_sync.sv
// Brings asynchronous event lines into clk and emits a one-cycle strobe per rising edge
`timescale 1ns/1ps
`include "lb_slave_defs.svh"

module event_sync #(
	parameter int N = `LB_N_EVENTS
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic [N-1:0] events,
	output logic [N-1:0] strb
);

	// Two-flop synchronizer stages
	logic [N-1:0] sync_1;
	logic [N-1:0] sync_2;
	// Previous synchronized level for edge detect
	logic [N-1:0] dly;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
			dly    <= '0;
		end else begin
			sync_1 <= events;
			sync_2 <= sync_1;
			dly    <= sync_2;
		end
	end

	// Edge register, strobe lasts exactly one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			strb <= '0;
		end else begin
			strb <= sync_2 & ~dly;
		end
	end

	// Net latency: sync_1, sync_2, then strb
	// so the counter moves on the third edge after capture

endmodule

// File: verilog/lb_slave_pkg.sv
// Shared bus, control and mirror types plus address enums for the local-bus slave
`include "lb_slave_defs.svh"

package lb_slave_pkg;

	// One bus cycle as seen by the slave
	typedef struct packed {
		logic [`LB_ADDR_W-1:0] addr;
		logic                  strobe;
		logic                  rd;
		logic [`LB_DATA_W-1:0] wdata;
	} lb_req_t;

	// Host-written settings, also the REG_CTRL readback layout
	typedef struct packed {
		logic       led_user;
		logic [7:0] duty_1;
		logic [7:0] duty_2;
	} ctrl_regs_t;

	// Single mirror write
	typedef struct packed {
		logic                     en;
		logic [`LB_MIRROR_AW-1:0] addr;
		logic [`LB_DATA_W-1:0]    data;
	} mirror_wr_t;

	// Pages on addr[23:16]
	typedef enum logic [`LB_PAGE_HI-`LB_PAGE_LO:0] {
		PAGE_REGS   = 8'h00,
		PAGE_EVENTS = 8'h01,
		PAGE_CTRL   = 8'h05
	} lb_page_e;

	// Page 0 read offsets
	typedef enum logic [3:0] {
		REG_ID0    = 4'd0,
		REG_ID1    = 4'd1,
		REG_UPTIME = 4'd2,
		REG_CTRL   = 4'd3
	} lb_reg_e;

	// Page 5 write offsets with side effects
	typedef enum logic [3:0] {
		WR_LED_USER  = 4'd1,
		WR_DUTY_1    = 4'd2,
		WR_DUTY_2    = 4'd3,
		WR_CNT_CLEAR = 4'd4
	} lb_wr_e;

endpackage

// File: include/lb_slave_defs.svh
// Address map, bus widths and channel counts for the local-bus slave, included by package and RTL
`ifndef LB_SLAVE_DEFS_SVH
`define LB_SLAVE_DEFS_SVH

// Bus widths
`define LB_ADDR_W 24
`define LB_DATA_W 32

// Page select field inside the bus address
`define LB_PAGE_HI 23
`define LB_PAGE_LO 16

// Event channels and their counter width
`define LB_N_EVENTS 4
`define LB_EVT_CNT_W 16

// PWM counter width, 10 bits gives a 1024-cycle period
`define LB_PWM_CW 10

// Mirror memory, 32 words
`define LB_MIRROR_AW 5

// Identification words on page 0
`define LB_ID_0 "LBSL"
`define LB_ID_1 "v1.0"

// Returned for anything not decoded
`define LB_UNMAPPED 32'hdeadbeef

`endif
